// File: verilog/input_params.svh
/*
 * Player input constants
 * Game codes, APB register map and keyboard codes of both key tables
 */
`ifndef INPUT_PARAMS_SVH
`define INPUT_PARAMS_SVH

// ########################################
// Game codes and register map
`define GAME_TYPE_RST 8'd104 // Four-player default game
`define GAME_TANK     8'd118 // Two-player tank game
`define APB_AW        4      // APB address width
`define REG_GAME      4'h0
`define REG_SVC       4'h4   // Service switch in bit 0

// ########################################
// Standard four-player table
`define KEY_STD_P1_UP    9'h175 // Cursor keys
`define KEY_STD_P1_DOWN  9'h172
`define KEY_STD_P1_LEFT  9'h16B
`define KEY_STD_P1_RIGHT 9'h174
`define KEY_STD_P1_FIRE  9'h014 // Left ctrl
`define KEY_STD_P1_MAGIC 9'h011 // Left alt
`define KEY_STD_P2_UP    9'h02D // R
`define KEY_STD_P2_DOWN  9'h02B // F
`define KEY_STD_P2_LEFT  9'h023 // D
`define KEY_STD_P2_RIGHT 9'h034 // G
`define KEY_STD_P2_FIRE  9'h01C
`define KEY_STD_P2_MAGIC 9'h01B
`define KEY_STD_P3_UP    9'h043 // I, K, J, L
`define KEY_STD_P3_DOWN  9'h042
`define KEY_STD_P3_LEFT  9'h03B
`define KEY_STD_P3_RIGHT 9'h04B
`define KEY_STD_P3_FIRE  9'h114 // Right ctrl
`define KEY_STD_P3_MAGIC 9'h059 // Right shift
`define KEY_STD_P4_UP    9'h075 // Numpad 8, 2, 4, 6
`define KEY_STD_P4_DOWN  9'h072
`define KEY_STD_P4_LEFT  9'h06B
`define KEY_STD_P4_RIGHT 9'h074
`define KEY_STD_P4_FIRE  9'h070 // Numpad 0
`define KEY_STD_P4_MAGIC 9'h071
`define KEY_COIN1        9'h02E // Digits 5 to 8, shared by both tables
`define KEY_COIN2        9'h036
`define KEY_COIN3        9'h03D
`define KEY_COIN4        9'h03E

// ########################################
// Tank table, two treads per player
`define KEY_TANK_P1_RBACK  9'h023
`define KEY_TANK_P1_LBACK  9'h01B
`define KEY_TANK_P1_RFORW  9'h024
`define KEY_TANK_P1_LFORW  9'h01D
`define KEY_TANK_P1_RTHUMB 9'h02D
`define KEY_TANK_P1_LTHUMB 9'h015
`define KEY_TANK_P1_RTRIG  9'h02B
`define KEY_TANK_P1_LTRIG  9'h01C
`define KEY_TANK_P2_RBACK  9'h042
`define KEY_TANK_P2_LBACK  9'h03B
`define KEY_TANK_P2_RFORW  9'h043
`define KEY_TANK_P2_LFORW  9'h03C
`define KEY_TANK_P2_RTHUMB 9'h044
`define KEY_TANK_P2_LTHUMB 9'h035
`define KEY_TANK_P2_RTRIG  9'h04B
`define KEY_TANK_P2_LTRIG  9'h033
`define KEY_TANK_START1    9'h016 // Digit 1
`define KEY_TANK_START2    9'h01E

`endif

// File: verilog/input_pkg.sv
/*
 * Shared types of the player input block
 */
package input_pkg;

	typedef logic [7:0] player_port_t; // One player port, active high inside
	typedef logic [4:0] sys_port_t;    // Service, coin1, coin2, coin3, coin4 from the top

	// Keyboard code, bit 8 marks an extended key
	typedef logic [8:0] key_code_t;

	// Joystick word
	// [9] start, [8] coin, [7:4] buttons
	// [3] up, [2] down, [1] left, [0] right
	typedef logic [9:0] joy_t;

	typedef logic [7:0] game_type_t; // Game code register
	typedef logic [3:0] tread_t;     // W fwd, W back, X fwd, X back from the top
	typedef logic [3:0] btn_t;       // Four stick buttons

	// Port layout picked by the merge stage
	typedef enum logic {
		LAYOUT_STD,  // Four players, eight-way sticks
		LAYOUT_TANK  // Two players, tread controls
	} layout_e;

endpackage

// File: verilog/input_if.sv
/*
 * Interfaces between the input stages and the merge stage
 * Both layouts travel side by side, the merge picks one
 */
interface key_bank_if import input_pkg::*; ();
	player_port_t std_p1;     // Standard bank bytes
	player_port_t std_p2;
	player_port_t std_p3;
	player_port_t std_p4;
	logic [3:0]   std_coin;   // Bit n is coin n+1
	player_port_t tank_p1;    // Tank bank bytes
	player_port_t tank_p2;
	logic [1:0]   tank_start; // Bit 0 is P1 start
	logic [1:0]   tank_coin;  // Coins 1 and 2

	modport src (output std_p1, std_p2, std_p3, std_p4, std_coin,
		tank_p1, tank_p2, tank_start, tank_coin);
	modport snk (input std_p1, std_p2, std_p3, std_p4, std_coin,
		tank_p1, tank_p2, tank_start, tank_coin);
endinterface

interface stick_if import input_pkg::*; ();
	player_port_t [3:0] direct; // Directions over buttons, one per stick
	tread_t       [1:0] tread;  // Tank commands, sticks 0 and 1
	btn_t         [1:0] btn;
	logic         [3:0] coin;   // Bit n from stick n
	logic         [3:0] start;

	modport src (output direct, tread, btn, coin, start);
	modport snk (input direct, tread, btn, coin, start);
endinterface

// File: verilog/cfg_regs.sv
/*
 * APB configuration slave
 * Holds the game type and the service switch, zero wait states
 */
`include "input_params.svh"

module cfg_regs import input_pkg::*; (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [`APB_AW-1:0] paddr,
	input  logic [7:0]         pwdata,
	output logic [7:0]         prdata,
	output logic               pready,
	output logic               pslverr,
	output layout_e            layout,
	output logic               service
);

	game_type_t game_type;
	logic       access;   // Access phase, completes this cycle
	logic       hit_game;
	logic       hit_svc;

	assign pready   = 1'b1; // Never stalls
	assign access   = psel & penable & pready;
	assign hit_game = (paddr == `REG_GAME);
	assign hit_svc  = (paddr == `REG_SVC);
	assign pslverr  = access & ~(hit_game | hit_svc); // Unmapped offset

	// ########################################
	// Register writes
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			game_type <= `GAME_TYPE_RST;
			service   <= 1'b0; // Switch off
		end else if (access && pwrite) begin
			if (hit_game)
				game_type <= pwdata;
			if (hit_svc)
				service <= pwdata[0];
		end
	end

	// Read mux, zero for unmapped offsets
	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			if (hit_game)
				prdata = game_type;
			else if (hit_svc)
				prdata = {7'd0, service};
		end
	end

	// Only the tank game uses the tread layout
	assign layout = (game_type == `GAME_TANK) ? LAYOUT_TANK : LAYOUT_STD;

endmodule

// File: verilog/key_matrix.sv
/*
 * Keyboard event decoder
 * Latches press and release into the standard and the tank key banks
 */
`include "input_params.svh"

module key_matrix import input_pkg::*; (
	input  logic      clk_sys,
	input  logic      rst_n,
	input  key_code_t key_code,
	input  logic      key_pressed,
	input  logic      key_toggle,
	key_bank_if.src   bank
);

	logic toggle_q; // Toggle level of the last clock
	logic key_evt;

	assign key_evt = (key_toggle != toggle_q); // Any edge is a new event

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			toggle_q        <= 1'b0;
			bank.std_p1     <= '0;
			bank.std_p2     <= '0;
			bank.std_p3     <= '0;
			bank.std_p4     <= '0;
			bank.std_coin   <= '0;
			bank.tank_p1    <= '0;
			bank.tank_p2    <= '0;
			bank.tank_start <= '0;
			bank.tank_coin  <= '0;
		end else begin
			toggle_q <= key_toggle;
			if (key_evt) begin
				// ########################################
				// Standard bank, up down left right in 7:4
				case (key_code)
					`KEY_STD_P1_UP:    bank.std_p1[7] <= key_pressed;
					`KEY_STD_P1_DOWN:  bank.std_p1[6] <= key_pressed;
					`KEY_STD_P1_LEFT:  bank.std_p1[5] <= key_pressed;
					`KEY_STD_P1_RIGHT: bank.std_p1[4] <= key_pressed;
					`KEY_STD_P1_FIRE:  bank.std_p1[1] <= key_pressed;
					`KEY_STD_P1_MAGIC: bank.std_p1[0] <= key_pressed;
					`KEY_STD_P2_UP:    bank.std_p2[7] <= key_pressed;
					`KEY_STD_P2_DOWN:  bank.std_p2[6] <= key_pressed;
					`KEY_STD_P2_LEFT:  bank.std_p2[5] <= key_pressed;
					`KEY_STD_P2_RIGHT: bank.std_p2[4] <= key_pressed;
					`KEY_STD_P2_FIRE:  bank.std_p2[1] <= key_pressed;
					`KEY_STD_P2_MAGIC: bank.std_p2[0] <= key_pressed;
					`KEY_STD_P3_UP:    bank.std_p3[7] <= key_pressed;
					`KEY_STD_P3_DOWN:  bank.std_p3[6] <= key_pressed;
					`KEY_STD_P3_LEFT:  bank.std_p3[5] <= key_pressed;
					`KEY_STD_P3_RIGHT: bank.std_p3[4] <= key_pressed;
					`KEY_STD_P3_FIRE:  bank.std_p3[1] <= key_pressed;
					`KEY_STD_P3_MAGIC: bank.std_p3[0] <= key_pressed;
					`KEY_STD_P4_UP:    bank.std_p4[7] <= key_pressed;
					`KEY_STD_P4_DOWN:  bank.std_p4[6] <= key_pressed;
					`KEY_STD_P4_LEFT:  bank.std_p4[5] <= key_pressed;
					`KEY_STD_P4_RIGHT: bank.std_p4[4] <= key_pressed;
					`KEY_STD_P4_FIRE:  bank.std_p4[1] <= key_pressed;
					`KEY_STD_P4_MAGIC: bank.std_p4[0] <= key_pressed;
					`KEY_COIN1:        bank.std_coin[0] <= key_pressed;
					`KEY_COIN2:        bank.std_coin[1] <= key_pressed;
					`KEY_COIN3:        bank.std_coin[2] <= key_pressed;
					`KEY_COIN4:        bank.std_coin[3] <= key_pressed;
					default: ;
				endcase
				// Tank bank, same event, codes may overlap the table above
				case (key_code)
					`KEY_TANK_P1_RBACK:  bank.tank_p1[7] <= key_pressed;
					`KEY_TANK_P1_LBACK:  bank.tank_p1[6] <= key_pressed;
					`KEY_TANK_P1_RFORW:  bank.tank_p1[5] <= key_pressed;
					`KEY_TANK_P1_LFORW:  bank.tank_p1[4] <= key_pressed;
					`KEY_TANK_P1_RTHUMB: bank.tank_p1[3] <= key_pressed;
					`KEY_TANK_P1_LTHUMB: bank.tank_p1[2] <= key_pressed;
					`KEY_TANK_P1_RTRIG:  bank.tank_p1[1] <= key_pressed;
					`KEY_TANK_P1_LTRIG:  bank.tank_p1[0] <= key_pressed;
					`KEY_TANK_P2_RBACK:  bank.tank_p2[7] <= key_pressed;
					`KEY_TANK_P2_LBACK:  bank.tank_p2[6] <= key_pressed;
					`KEY_TANK_P2_RFORW:  bank.tank_p2[5] <= key_pressed;
					`KEY_TANK_P2_LFORW:  bank.tank_p2[4] <= key_pressed;
					`KEY_TANK_P2_RTHUMB: bank.tank_p2[3] <= key_pressed;
					`KEY_TANK_P2_LTHUMB: bank.tank_p2[2] <= key_pressed;
					`KEY_TANK_P2_RTRIG:  bank.tank_p2[1] <= key_pressed;
					`KEY_TANK_P2_LTRIG:  bank.tank_p2[0] <= key_pressed;
					`KEY_TANK_START1:    bank.tank_start[0] <= key_pressed;
					`KEY_TANK_START2:    bank.tank_start[1] <= key_pressed;
					`KEY_COIN1:          bank.tank_coin[0] <= key_pressed;
					`KEY_COIN2:          bank.tank_coin[1] <= key_pressed;
					default: ;
				endcase
			end
		end
	end

endmodule

// File: verilog/stick_xlate.sv
/*
 * Joystick translation
 * Registers the direct form of every stick and tread commands of sticks 0 and 1
 */
module stick_xlate import input_pkg::*; (
	input  logic  clk_sys,
	input  logic  rst_n,
	input  joy_t  joy0,
	input  joy_t  joy1,
	input  joy_t  joy2,
	input  joy_t  joy3,
	stick_if.src  stick
);

	joy_t [3:0] joy;

	assign joy = {joy3, joy2, joy1, joy0};

	// Eight-way position to {W fwd, W back, X fwd, X back}
	function automatic tread_t tank_cmd(input logic [3:0] dir);
		case (dir) // Up, down, left, right
			4'b1000: tank_cmd = 4'b1010; // Both treads forward
			4'b0100: tank_cmd = 4'b0101; // Both back
			4'b0010: tank_cmd = 4'b0110; // Spin left
			4'b0001: tank_cmd = 4'b1001; // Spin right
			4'b1010: tank_cmd = 4'b0010; // Up-left
			4'b1001: tank_cmd = 4'b1000; // Up-right
			4'b0101: tank_cmd = 4'b0100; // Down-right
			4'b0110: tank_cmd = 4'b0001; // Down-left
			default: tank_cmd = 4'b0000; // Centre or impossible combos
		endcase
	endfunction

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			stick.direct <= '0;
			stick.tread  <= '0;
			stick.btn    <= '0;
			stick.coin   <= '0;
			stick.start  <= '0;
		end else begin
			for (int i = 0; i < 4; i++) begin
				stick.direct[i] <= {joy[i][3:0], joy[i][7:4]}; // Up lands in bit 7
				stick.coin[i]   <= joy[i][8];
				stick.start[i]  <= joy[i][9];
			end
			// Only two tanks
			for (int i = 0; i < 2; i++) begin
				stick.tread[i] <= tank_cmd(joy[i][3:0]);
				stick.btn[i]   <= joy[i][7:4];
			end
		end
	end

endmodule

// File: verilog/port_merge.sv
/*
 * Port merge
 * Picks the layout, ORs key and stick sources, drives active-low ports
 */
module port_merge import input_pkg::*; (
	input  logic         clk_sys,
	input  logic         rst_n,
	input  layout_e      layout,
	input  logic         service,
	key_bank_if.snk      bank,
	stick_if.snk         stick,
	output player_port_t p1_n,
	output player_port_t p2_n,
	output player_port_t p3_n,
	output player_port_t p4_n,
	output sys_port_t    sys_n
);

	player_port_t p1_d, p2_d, p3_d, p4_d; // Next port values, active low
	logic [3:0]   coin_key;
	logic [3:0]   coin_any;               // Bit n is coin n+1

	// Tread byte, X back, W back, X fwd, W fwd over buttons
	function automatic player_port_t tank_word(input tread_t t, input btn_t b);
		tank_word = {t[0], t[2], t[1], t[3], b};
	endfunction

	always_comb begin
		if (layout == LAYOUT_TANK) begin
			p1_d     = ~(bank.tank_p1 | tank_word(stick.tread[0], stick.btn[0]));
			p2_d     = ~(bank.tank_p2 | tank_word(stick.tread[1], stick.btn[1]));
			p3_d     = ~{6'd0, bank.tank_start | stick.start[1:0]}; // Start buttons
			p4_d     = '1;                                         // No fourth player
			coin_key = {2'b00, bank.tank_coin};                    // No coin 3 and 4 keys
		end else begin
			p1_d     = ~(bank.std_p1 | stick.direct[0]);
			p2_d     = ~(bank.std_p2 | stick.direct[1]);
			p3_d     = ~(bank.std_p3 | stick.direct[2]);
			p4_d     = ~(bank.std_p4 | stick.direct[3]);
			coin_key = bank.std_coin;
		end
	end

	assign coin_any = coin_key | stick.coin;

	// ########################################
	// Output register, all inactive in reset
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			p1_n  <= '1;
			p2_n  <= '1;
			p3_n  <= '1;
			p4_n  <= '1;
			sys_n <= '1;
		end else begin
			p1_n  <= p1_d;
			p2_n  <= p2_d;
			p3_n  <= p3_d;
			p4_n  <= p4_d;
			sys_n <= {~service, ~coin_any[0], ~coin_any[1], ~coin_any[2], ~coin_any[3]};
		end
	end

endmodule

// File: verilog/player_input_top.sv
/*
 * Player input block
 * Keyboard and joystick sources merged into four player ports and a system port
 */
`include "input_params.svh"

module player_input_top import input_pkg::*; (
	input  logic               clk_sys,
	input  logic               rst_n,
	// APB slave
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [`APB_AW-1:0] paddr,
	input  logic [7:0]         pwdata,
	output logic [7:0]         prdata,
	output logic               pready,
	output logic               pslverr,
	// Keyboard events
	input  key_code_t          key_code,
	input  logic               key_pressed,
	input  logic               key_toggle,
	// Joysticks
	input  joy_t               joy0,
	input  joy_t               joy1,
	input  joy_t               joy2,
	input  joy_t               joy3,
	// Active-low game ports
	output player_port_t       p1_n,
	output player_port_t       p2_n,
	output player_port_t       p3_n,
	output player_port_t       p4_n,
	output sys_port_t          sys_n
);

	layout_e layout;  // From the game type register
	logic    service;

	key_bank_if keys ();
	stick_if    sticks ();

	cfg_regs u_cfg (.clk_sys(clk_sys), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.layout(layout), .service(service));

	key_matrix u_keys (.clk_sys(clk_sys), .rst_n(rst_n), .key_code(key_code),
		.key_pressed(key_pressed), .key_toggle(key_toggle), .bank(keys.src));

	stick_xlate u_sticks (.clk_sys(clk_sys), .rst_n(rst_n),
		.joy0(joy0), .joy1(joy1), .joy2(joy2), .joy3(joy3), .stick(sticks.src));

	port_merge u_merge (.clk_sys(clk_sys), .rst_n(rst_n),
		.layout(layout), .service(service), .bank(keys.snk), .stick(sticks.snk),
		.p1_n(p1_n), .p2_n(p2_n), .p3_n(p3_n), .p4_n(p4_n), .sys_n(sys_n));

endmodule

// File: tb/player_input_props.sv
/*
 * Player input properties
 * APB ready rule, port state after reset
 */
module player_input_props import input_pkg::*; (
	input logic         clk_sys,
	input logic         rst_n,
	input logic         pready,
	input player_port_t p1_n,
	input player_port_t p2_n,
	input player_port_t p3_n,
	input player_port_t p4_n,
	input sys_port_t    sys_n
);
	timeunit 1ns;
	timeprecision 1ps;

	// Zero wait states
	ready_high: assert property (@(posedge clk_sys) pready)
		else $error("pready dropped low");

	// ########################################
	// Every port inactive once reset is seen
	ports_idle: assert property (@(posedge clk_sys) !rst_n |=>
		(p1_n == '1 && p2_n == '1 && p3_n == '1 && p4_n == '1 && sys_n == '1))
		else $error("Ports not inactive after reset");

endmodule

// File: tb/tb_player_input.sv
/*
 * Player input testbench
 * Directed tests over APB, keyboard events and joysticks
 */
`include "input_params.svh"

module tb_player_input import input_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WAIT_LIMIT = 16; // Cycles before a poll gives up

	// Stick positions {up, down, left, right} and expected p1_n[7:4]
	localparam logic [0:7][3:0] TANK_POS = {4'b1000, 4'b0100, 4'b0010, 4'b0001,
		4'b1010, 4'b1001, 4'b0101, 4'b0110};
	localparam logic [0:7][3:0] TANK_EXP = {4'b1100, 4'b0011, 4'b1001, 4'b0110,
		4'b1101, 4'b1110, 4'b1011, 4'b0111}; // X back, W back, X fwd, W fwd, low

	logic               clk_sys = 1'b0;
	logic               rst_n;
	logic               psel;
	logic               penable;
	logic               pwrite;
	logic [`APB_AW-1:0] paddr;
	logic [7:0]         pwdata;
	logic [7:0]         prdata;
	logic               pready;
	logic               pslverr;
	key_code_t          key_code;
	logic               key_pressed;
	logic               key_toggle;
	joy_t               joy0;
	joy_t               joy1;
	joy_t               joy2;
	joy_t               joy3;
	player_port_t       p1_n;
	player_port_t       p2_n;
	player_port_t       p3_n;
	player_port_t       p4_n;
	sys_port_t          sys_n;
	integer             seed = 32'h0267cf0e;
	logic [7:0]         rd_data;    // Last APB read
	logic               rd_err;
	int                 wait_edges; // Edges between drive and match

	player_input_top UUT (.clk_sys(clk_sys), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.key_code(key_code), .key_pressed(key_pressed), .key_toggle(key_toggle),
		.joy0(joy0), .joy1(joy1), .joy2(joy2), .joy3(joy3),
		.p1_n(p1_n), .p2_n(p2_n), .p3_n(p3_n), .p4_n(p4_n), .sys_n(sys_n));

	bind player_input_top player_input_props u_props (.clk_sys(clk_sys), .rst_n(rst_n),
		.pready(pready),
		.p1_n(p1_n), .p2_n(p2_n), .p3_n(p3_n), .p4_n(p4_n), .sys_n(sys_n));

	always #20 clk_sys = ~clk_sys; // 40 ns period

	// ########################################
	// Helpers
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "Run stopped");
	endtask

	task automatic check(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0t ns: %s, got %02h, expected %02h",
				$time, what, got, exp));
	endtask

	function automatic logic [7:0] port_value(input int sel);
		case (sel)
			0:       port_value = p1_n;
			1:       port_value = p2_n;
			2:       port_value = p3_n;
			3:       port_value = p4_n;
			default: port_value = 8'(sys_n);
		endcase
	endfunction

	// Poll at falling edges, outputs are settled there
	task automatic expect_port(input int sel, input logic [7:0] exp, input string what);
		int         n;
		logic [7:0] got;
		n = 0;
		do begin
			@(negedge clk_sys);
			got = port_value(sel);
			n++;
		end while (got !== exp && n < WAIT_LIMIT);
		wait_edges = n - 1; // First poll sits before the next rising edge
		check(got, exp, what);
	endtask

	task automatic key_event(input key_code_t code, input logic pressed);
		@(posedge clk_sys);
		key_code    <= code;
		key_pressed <= pressed;
		key_toggle  <= ~key_toggle; // Edge marks the event
	endtask

	// Setup then access phase, read data taken in the access phase
	task automatic apb_access(input logic write, input logic [`APB_AW-1:0] addr,
		input logic [7:0] data);
		int n;
		@(posedge clk_sys);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= write;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk_sys);
		penable <= 1'b1;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
			if (n > WAIT_LIMIT)
				abort_run("APB transfer never completed, pready stayed low");
		end while (!pready);
		rd_data = prdata;
		rd_err  = pslverr;
		@(posedge clk_sys); // Transfer completes here
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	// ########################################
	// Directed tests
	task automatic reset_defaults();
		expect_port(0, 8'hFF, "p1_n after reset");
		expect_port(1, 8'hFF, "p2_n after reset");
		expect_port(2, 8'hFF, "p3_n after reset");
		expect_port(3, 8'hFF, "p4_n after reset");
		expect_port(4, 8'h1F, "sys_n after reset"); // Service off, no coins
		apb_access(1'b0, `REG_GAME, 8'h00);
		check(rd_data, 8'd104, "game type after reset");
		check(8'(rd_err), 8'd0, "pslverr on game type read");
	endtask

	task automatic std_keys();
		key_event(`KEY_STD_P1_UP, 1'b1);
		expect_port(0, 8'h7F, "p1_n with P1 up held");
		check(8'(wait_edges), 8'd2, "key event to port latency");
		key_event(`KEY_STD_P1_UP, 1'b0);
		expect_port(0, 8'hFF, "p1_n after P1 up release");
		key_event(`KEY_COIN3, 1'b1);
		expect_port(4, 8'h1D, "sys_n with coin3 held"); // Coin3 sits in bit 1
		key_event(`KEY_COIN3, 1'b0);
		expect_port(4, 8'h1F, "sys_n after coin3 release");
	endtask

	task automatic std_sticks();
		joy_t j [4];
		for (int r = 0; r < 8; r++) begin
			for (int i = 0; i < 4; i++)
				j[i] = joy_t'($random(seed));
			@(posedge clk_sys);
			joy0 <= j[0];
			joy1 <= j[1];
			joy2 <= j[2];
			joy3 <= j[3];
			// Directions over buttons, active low
			expect_port(0, ~{j[0][3:0], j[0][7:4]}, "p1_n from joy0");
			expect_port(1, ~{j[1][3:0], j[1][7:4]}, "p2_n from joy1");
			expect_port(2, ~{j[2][3:0], j[2][7:4]}, "p3_n from joy2");
			expect_port(3, ~{j[3][3:0], j[3][7:4]}, "p4_n from joy3");
			expect_port(4, {3'b000, 1'b1, ~j[0][8], ~j[1][8], ~j[2][8], ~j[3][8]},
				"sys_n coins from sticks");
		end
		@(posedge clk_sys);
		joy0 <= '0;
		joy1 <= '0;
		joy2 <= '0;
		joy3 <= '0;
		expect_port(3, 8'hFF, "p4_n with sticks centred");
	endtask

	task automatic tank_layout();
		apb_access(1'b1, `REG_GAME, 8'd118);
		apb_access(1'b0, `REG_GAME, 8'h00);
		check(rd_data, 8'd118, "game type readback");
		for (int k = 0; k < 8; k++) begin
			@(posedge clk_sys);
			joy0 <= {2'b00, 4'b0101, TANK_POS[k]}; // Fixed button pattern
			expect_port(0, {TANK_EXP[k], 4'b1010}, $sformatf("p1_n tank position %0d", k));
		end
		@(posedge clk_sys);
		joy0 <= '0;
		expect_port(0, 8'hFF, "p1_n with stick centred");
		key_event(`KEY_TANK_P1_RBACK, 1'b1);
		expect_port(0, 8'h7F, "p1_n with right tread back key");
		expect_port(3, 8'hFF, "p4_n in tank layout");
		key_event(`KEY_TANK_P1_RBACK, 1'b0);
		expect_port(0, 8'hFF, "p1_n after tread key release");
	endtask

	task automatic service_and_errors();
		apb_access(1'b1, `REG_SVC, 8'h01);
		expect_port(4, 8'h0F, "sys_n with service on");
		apb_access(1'b0, `REG_SVC, 8'h00);
		check(rd_data, 8'h01, "service readback");
		apb_access(1'b0, 4'h8, 8'h00);  // Unmapped
		check(8'(rd_err), 8'd1, "pslverr on unmapped read");
		check(rd_data, 8'h00, "read data on unmapped read");
		apb_access(1'b1, 4'hC, 8'h55); // Must change nothing
		check(8'(rd_err), 8'd1, "pslverr on unmapped write");
		apb_access(1'b0, `REG_GAME, 8'h00);
		check(rd_data, 8'd118, "game type after unmapped write");
	endtask

	// ########################################
	// Sequence
	initial begin
		rst_n       = 1'b0;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		key_code    = '0;
		key_pressed = 1'b0;
		key_toggle  = 1'b0;
		joy0        = '0;
		joy1        = '0;
		joy2        = '0;
		joy3        = '0;
		repeat (3) @(posedge clk_sys);
		rst_n <= 1'b1;
		reset_defaults();
		std_keys();
		std_sticks();
		tank_layout();
		service_and_errors();
		$display("TEST OK");
		$finish;
	end

endmodule

// File: all.f
+incdir+verilog
verilog/input_pkg.sv
verilog/input_if.sv
verilog/cfg_regs.sv
verilog/key_matrix.sv
verilog/stick_xlate.sv
verilog/port_merge.sv
verilog/player_input_top.sv
tb/player_input_props.sv
tb/tb_player_input.sv

// File: Makefile
# Verilator build and run of the player input testbench
TOP := tb_player_input

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails unless the pass line is seen"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) -f all.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf obj_dir
